/* build.f */
src/irc_pkg.sv
src/irc_factor.sv
src/irc_arbiter.sv
src/irc_regs.sv
src/irc_top.sv
tb/irc_assertions.sv
tb/irc_tb.sv

/* run.sh */
#!/usr/bin/env bash
# build and run the interrupt controller testbench with Verilator
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert --timescale 1ns/100ps \
    -f build.f --top-module irc_tb -o irc_sim

./obj_dir/irc_sim

/* src/irc_arbiter.sv */
module irc_arbiter
    import irc_pkg::*;
(
    input  logic                       clk,
    input  logic                       reset,

    input  logic                       enable_i,
    input  logic [PRIORITY_WIDTH-1:0]  mask_i,

    // wired-AND line and round control
    input  logic                       line_i,
    output logic                       round_start_o,
    output logic                       arb_reset_o,

    // winner and cpu request
    output logic [PRIORITY_WIDTH-1:0]  req_priority_o,
    output logic [FACTOR_ID_WIDTH-1:0] req_factor_id_o,
    output logic                       cpu_irq_o
);

    localparam logic [PACKET_WIDTH:0] SLOT_FIRST = (PACKET_WIDTH + 1)'(1);

    // one-hot slot counter, bit 0 is the start slot
    logic [PACKET_WIDTH:0]   slot;
    logic [PACKET_WIDTH-2:0] recv;
    logic                    prev_enable;

    assign round_start_o = slot[0];
    assign arb_reset_o   = ~enable_i;

    // ------------------------------------------------------------
    // round counter and receiver
    // ------------------------------------------------------------

    always_ff @(posedge clk) begin
        if (reset) begin
            slot <= SLOT_FIRST;
        end else if (enable_i) begin
            slot <= {slot[PACKET_WIDTH-1:0], slot[PACKET_WIDTH]};
        end else begin
            slot <= SLOT_FIRST;
        end
    end

    // bits from slots 1..4 collect here, slot 5 supplies the last
    always_ff @(posedge clk) begin
        recv <= {recv[PACKET_WIDTH-3:0], line_i};
    end

    // ------------------------------------------------------------
    // winner registers
    // ------------------------------------------------------------

    always_ff @(posedge clk) begin
        if (reset) begin
            prev_enable     <= 1'b0;
            req_priority_o  <= '1;
            req_factor_id_o <= '0;
        end else begin
            prev_enable <= enable_i;
            if (enable_i) begin
                // fresh start after enable
                if (!prev_enable) begin
                    req_priority_o <= '1;
                end
                if (slot[PACKET_WIDTH]) begin
                    {req_priority_o, req_factor_id_o} <= {recv, line_i};
                end
            end
        end
    end

    assign cpu_irq_o = enable_i & prev_enable & (req_priority_o < mask_i);

endmodule

/* src/irc_factor.sv */
module irc_factor
    import irc_pkg::*;
#(
    parameter int FACTOR_ID = 0
) (
    input  logic                 clk,
    input  logic                 reset,

    // interrupt source
    input  logic                 irq_i,

    // register access, already decoded for this factor
    input  logic                 stb_i,
    input  logic                 we_i,
    input  logic [1:0]           adr_i,
    input  logic [DAT_WIDTH-1:0] dat_i,
    output logic [DAT_WIDTH-1:0] dat_o,

    // serial arbitration
    input  logic                 round_start_i,
    input  logic                 arb_reset_i,
    input  logic                 line_i,
    output logic                 send_o
);

    localparam logic [FACTOR_ID_WIDTH-1:0] ID = FACTOR_ID_WIDTH'(FACTOR_ID);

    logic                      enable;
    logic                      pending;
    logic [PRIORITY_WIDTH-1:0] priority_q;
    logic                      irq_d;
    logic                      irq_rise;
    logic                      wr;

    logic [PACKET_WIDTH-1:0]   shift;
    logic                      participating;

    assign irq_rise = irq_i & ~irq_d;
    assign wr       = stb_i & we_i;

    // ------------------------------------------------------------
    // registers and pending latch
    // ------------------------------------------------------------

    always_ff @(posedge clk) begin
        if (reset) begin
            enable     <= 1'b0;
            pending    <= 1'b0;
            priority_q <= '0;
            irq_d      <= 1'b0;
        end else begin
            irq_d <= irq_i;

            if (wr && adr_i == FACTOR_ADR_ENABLE) begin
                enable <= dat_i[0];
            end
            if (wr && adr_i == FACTOR_ADR_PRIORITY) begin
                priority_q <= dat_i[PRIORITY_WIDTH-1:0];
            end

            // a fresh edge beats a clear in the same cycle
            if (irq_rise) begin
                pending <= 1'b1;
            end else if (wr && adr_i == FACTOR_ADR_PENDING && dat_i[0]) begin
                pending <= 1'b0;
            end
        end
    end

    always_comb begin
        dat_o = '0;
        if (stb_i) begin
            case (adr_i)
                FACTOR_ADR_ENABLE:   dat_o = DAT_WIDTH'(enable);
                FACTOR_ADR_PENDING:  dat_o = DAT_WIDTH'(pending);
                FACTOR_ADR_PRIORITY: dat_o = DAT_WIDTH'(priority_q);
                FACTOR_ADR_LEVEL:    dat_o = DAT_WIDTH'(irq_i);
                default:             dat_o = '0;
            endcase
        end
    end

    // ------------------------------------------------------------
    // arbitration sender
    // ------------------------------------------------------------

    // packet goes out msb first, priority then id
    always_ff @(posedge clk) begin
        if (round_start_i) begin
            shift <= {priority_q, ID};
        end else begin
            shift <= {shift[PACKET_WIDTH-2:0], 1'b0};
        end
    end

    always_ff @(posedge clk) begin
        if (reset || arb_reset_i) begin
            participating <= 1'b0;
        end else if (round_start_i) begin
            participating <= enable & pending;
        end else if (send_o && !line_i) begin
            // someone sent a smaller bit
            participating <= 1'b0;
        end
    end

    // idle factors release the line
    assign send_o = ~participating | shift[PACKET_WIDTH-1];

endmodule

/* src/irc_pkg.sv */
package irc_pkg;

    // ------------------------------------------------------------
    // sizes
    // ------------------------------------------------------------

    localparam int FACTOR_ID_WIDTH = 2;
    localparam int FACTOR_NUM      = 4;

    // lower value is more urgent
    localparam int PRIORITY_WIDTH  = 3;

    // one round is PACKET_WIDTH + 1 slots
    localparam int PACKET_WIDTH    = PRIORITY_WIDTH + FACTOR_ID_WIDTH;

    localparam int ADR_WIDTH       = 16;
    localparam int DAT_WIDTH       = 32;

    // ------------------------------------------------------------
    // controller register map (word addresses)
    // ------------------------------------------------------------

    localparam logic [ADR_WIDTH-1:0] ADR_ENABLE        = 16'd0;
    localparam logic [ADR_WIDTH-1:0] ADR_MASK          = 16'd1;
    localparam logic [ADR_WIDTH-1:0] ADR_REQ_FACTOR_ID = 16'd2;
    localparam logic [ADR_WIDTH-1:0] ADR_REQ_PRIORITY  = 16'd3;
    localparam logic [ADR_WIDTH-1:0] ADR_FACTOR_NUM    = 16'd4;
    localparam logic [ADR_WIDTH-1:0] ADR_PRIORITY_MAX  = 16'd5;

    // factor i sits at ADR_FACTOR_BASE + 4*i
    localparam logic [ADR_WIDTH-1:0] ADR_FACTOR_BASE   = 16'd8;

    // offsets inside one factor block
    localparam logic [1:0] FACTOR_ADR_ENABLE   = 2'd0;
    localparam logic [1:0] FACTOR_ADR_PENDING  = 2'd1;
    localparam logic [1:0] FACTOR_ADR_PRIORITY = 2'd2;
    localparam logic [1:0] FACTOR_ADR_LEVEL    = 2'd3;

endpackage

/* src/irc_regs.sv */
module irc_regs
    import irc_pkg::*;
(
    input  logic                                 clk,
    input  logic                                 reset,

    // bus
    input  logic                                 stb_i,
    input  logic                                 we_i,
    input  logic [ADR_WIDTH-1:0]                 adr_i,
    input  logic [DAT_WIDTH-1:0]                 dat_i,
    output logic [DAT_WIDTH-1:0]                 dat_o,
    output logic                                 ack_o,

    // arbiter status
    input  logic [PRIORITY_WIDTH-1:0]            req_priority_i,
    input  logic [FACTOR_ID_WIDTH-1:0]           req_factor_id_i,

    // factor blocks
    input  logic [FACTOR_NUM-1:0][DAT_WIDTH-1:0] factor_dat_i,
    output logic [FACTOR_NUM-1:0]                factor_stb_o,

    output logic                                 enable_o,
    output logic [PRIORITY_WIDTH-1:0]            mask_o
);

    logic                 wr;
    logic [DAT_WIDTH-1:0] factor_or;

    assign wr    = stb_i & we_i;
    assign ack_o = stb_i;

    always_ff @(posedge clk) begin
        if (reset) begin
            enable_o <= 1'b0;
            mask_o   <= '1;
        end else begin
            if (wr && adr_i == ADR_ENABLE) begin
                enable_o <= dat_i[0];
            end
            if (wr && adr_i == ADR_MASK) begin
                mask_o <= dat_i[PRIORITY_WIDTH-1:0];
            end
        end
    end

    // ------------------------------------------------------------
    // factor block decode
    // ------------------------------------------------------------

    for (genvar i = 0; i < FACTOR_NUM; i++) begin : g_sel
        assign factor_stb_o[i] = stb_i &&
            (adr_i[ADR_WIDTH-1:2] == (ADR_WIDTH-2)'(ADR_FACTOR_BASE[ADR_WIDTH-1:2] + i));
    end

    // unselected factors return zero
    always_comb begin
        factor_or = '0;
        for (int i = 0; i < FACTOR_NUM; i++) begin
            factor_or = factor_or | factor_dat_i[i];
        end
    end

    always_comb begin
        case (adr_i)
            ADR_ENABLE:        dat_o = DAT_WIDTH'(enable_o);
            ADR_MASK:          dat_o = DAT_WIDTH'(mask_o);
            ADR_REQ_FACTOR_ID: dat_o = DAT_WIDTH'(req_factor_id_i);
            ADR_REQ_PRIORITY:  dat_o = DAT_WIDTH'(req_priority_i);
            ADR_FACTOR_NUM:    dat_o = DAT_WIDTH'(FACTOR_NUM);
            ADR_PRIORITY_MAX:  dat_o = DAT_WIDTH'({PRIORITY_WIDTH{1'b1}});
            default:           dat_o = factor_or;
        endcase
    end

endmodule

/* src/irc_top.sv */
module irc_top
    import irc_pkg::*;
(
    input  logic                  clk,
    input  logic                  reset,

    input  logic [FACTOR_NUM-1:0] irq_i,

    // control bus
    input  logic [ADR_WIDTH-1:0]  bus_adr_i,
    input  logic [DAT_WIDTH-1:0]  bus_dat_i,
    input  logic                  bus_we_i,
    input  logic                  bus_stb_i,
    output logic [DAT_WIDTH-1:0]  bus_dat_o,
    output logic                  bus_ack_o,

    output logic                  cpu_irq_o
);

    logic                                 enable;
    logic [PRIORITY_WIDTH-1:0]            mask;
    logic [PRIORITY_WIDTH-1:0]            req_priority;
    logic [FACTOR_ID_WIDTH-1:0]           req_factor_id;
    logic                                 round_start;
    logic                                 arb_reset;
    logic                                 line;
    logic [FACTOR_NUM-1:0]                send;
    logic [FACTOR_NUM-1:0]                factor_stb;
    logic [FACTOR_NUM-1:0][DAT_WIDTH-1:0] factor_dat;

    // wired-AND arbitration line
    assign line = &send;

    irc_regs i_regs (
        .clk             (clk),
        .reset           (reset),
        .stb_i           (bus_stb_i),
        .we_i            (bus_we_i),
        .adr_i           (bus_adr_i),
        .dat_i           (bus_dat_i),
        .dat_o           (bus_dat_o),
        .ack_o           (bus_ack_o),
        .req_priority_i  (req_priority),
        .req_factor_id_i (req_factor_id),
        .factor_dat_i    (factor_dat),
        .factor_stb_o    (factor_stb),
        .enable_o        (enable),
        .mask_o          (mask)
    );

    irc_arbiter i_arbiter (
        .clk             (clk),
        .reset           (reset),
        .enable_i        (enable),
        .mask_i          (mask),
        .line_i          (line),
        .round_start_o   (round_start),
        .arb_reset_o     (arb_reset),
        .req_priority_o  (req_priority),
        .req_factor_id_o (req_factor_id),
        .cpu_irq_o       (cpu_irq_o)
    );

    for (genvar i = 0; i < FACTOR_NUM; i++) begin : g_factor
        irc_factor #(
            .FACTOR_ID (i)
        ) i_factor (
            .clk           (clk),
            .reset         (reset),
            .irq_i         (irq_i[i]),
            .stb_i         (factor_stb[i]),
            .we_i          (bus_we_i),
            .adr_i         (bus_adr_i[1:0]),
            .dat_i         (bus_dat_i),
            .dat_o         (factor_dat[i]),
            .round_start_i (round_start),
            .arb_reset_i   (arb_reset),
            .line_i        (line),
            .send_o        (send[i])
        );
    end

endmodule

/* tb/irc_assertions.sv */
module irc_assertions
    import irc_pkg::*;
(
    input logic                  clk,
    input logic                  reset,
    input logic                  stb_i,
    input logic                  ack_i,
    input logic                  enable_i,
    input logic                  cpu_irq_i,
    input logic [PACKET_WIDTH:0] slot_i
);
    timeunit 1ns;
    timeprecision 100ps;

    // single-cycle bus, ack mirrors strobe
    ack_follows_stb: assert property (@(posedge clk) disable iff (reset) ack_i == stb_i)
        else $error("bus acknowledge does not follow the strobe");

    irq_low_when_disabled: assert property (@(posedge clk) disable iff (reset)
        !enable_i |-> !cpu_irq_i)
        else $error("cpu interrupt raised while the controller is disabled");

    // exactly one slot active
    slot_one_hot: assert property (@(posedge clk) disable iff (reset) $onehot(slot_i))
        else $error("round counter is not one-hot");

endmodule

bind irc_top irc_assertions i_assertions (
    .clk       (clk),
    .reset     (reset),
    .stb_i     (bus_stb_i),
    .ack_i     (bus_ack_o),
    .enable_i  (enable),
    .cpu_irq_i (cpu_irq_o),
    .slot_i    (i_arbiter.slot)
);

/* tb/irc_tb.sv */
module irc_tb
    import irc_pkg::*;
();
    timeunit 1ns;
    timeprecision 100ps;

    localparam int N_ITER          = 200;
    localparam int CYCLES_PER_ITER = 40;
    localparam int SETTLE_CYCLES   = 14;
    localparam int WATCHDOG_CYCLES = N_ITER * CYCLES_PER_ITER + 200;

    logic                  clk;
    logic                  reset;
    logic [FACTOR_NUM-1:0] irq;
    logic [ADR_WIDTH-1:0]  bus_adr;
    logic [DAT_WIDTH-1:0]  bus_dat_w;
    logic [DAT_WIDTH-1:0]  bus_dat_r;
    logic                  bus_we;
    logic                  bus_stb;
    logic                  bus_ack;
    logic                  cpu_irq;

    // reference model state
    logic                      m_enable;
    logic [PRIORITY_WIDTH-1:0] m_mask;
    logic [FACTOR_NUM-1:0]     f_en;
    logic [FACTOR_NUM-1:0]     f_pend;
    logic [PRIORITY_WIDTH-1:0] f_pri [FACTOR_NUM];
    logic [FACTOR_NUM-1:0]     irq_cur;

    logic [31:0] lfsr = 32'h170f;

    irc_top i_dut (
        .clk       (clk),
        .reset     (reset),
        .irq_i     (irq),
        .bus_adr_i (bus_adr),
        .bus_dat_i (bus_dat_w),
        .bus_we_i  (bus_we),
        .bus_stb_i (bus_stb),
        .bus_dat_o (bus_dat_r),
        .bus_ack_o (bus_ack),
        .cpu_irq_o (cpu_irq)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge clk);
        $display("watchdog timeout, the test did not finish in time");
        $display("Simulation failed");
        $fatal(1, "watchdog expired");
    end

    // ------------------------------------------------------------
    // helpers
    // ------------------------------------------------------------

    // fibonacci lfsr with taps 32 22 2 1 and one step per bit
    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] r;
        logic        fb;
        r = '0;
        for (int k = 0; k < n; k++) begin
            fb   = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
            lfsr = {lfsr[30:0], fb};
            r    = {r[30:0], fb};
        end
        return r;
    endfunction

    function automatic logic [ADR_WIDTH-1:0] factor_adr(input int i, input logic [1:0] off);
        return ADR_FACTOR_BASE + ADR_WIDTH'(4 * i) + ADR_WIDTH'(off);
    endfunction

    // lowest {priority, id} among enabled and pending factors
    function automatic logic [PACKET_WIDTH-1:0] expected_packet();
        logic [PACKET_WIDTH-1:0] best;
        logic [PACKET_WIDTH-1:0] cand;
        best = '1;
        for (int i = 0; i < FACTOR_NUM; i++) begin
            cand = {f_pri[i], FACTOR_ID_WIDTH'(i)};
            if (f_en[i] && f_pend[i] && cand < best) begin
                best = cand;
            end
        end
        return best;
    endfunction

    task automatic check_equal(input logic [31:0] actual, input logic [31:0] expected,
                               input string what);
        if (actual !== expected) begin
            $display("ERROR at %0t ns: %s, got %0h, expected %0h",
                     $time, what, actual, expected);
            $display("Simulation failed");
            $fatal(1, "value mismatch");
        end
    endtask

    task automatic bus_write(input logic [ADR_WIDTH-1:0] adr, input logic [DAT_WIDTH-1:0] dat);
        @(posedge clk);
        bus_stb   <= 1'b1;
        bus_we    <= 1'b1;
        bus_adr   <= adr;
        bus_dat_w <= dat;
        @(posedge clk);
        bus_stb <= 1'b0;
        bus_we  <= 1'b0;
    endtask

    task automatic bus_read(input logic [ADR_WIDTH-1:0] adr, output logic [DAT_WIDTH-1:0] dat);
        @(posedge clk);
        bus_stb <= 1'b1;
        bus_we  <= 1'b0;
        bus_adr <= adr;
        @(negedge clk);
        check_equal(32'(bus_ack), 32'd1, "bus acknowledge");
        dat = bus_dat_r;
        @(posedge clk);
        bus_stb <= 1'b0;
    endtask

    task automatic check_read(input logic [ADR_WIDTH-1:0] adr, input logic [31:0] expected,
                              input string what);
        logic [DAT_WIDTH-1:0] dat;
        bus_read(adr, dat);
        check_equal(dat, expected, what);
    endtask

    // a rising input sets pending
    task automatic drive_irq(input logic [FACTOR_NUM-1:0] val);
        @(posedge clk);
        f_pend  = f_pend | (val & ~irq_cur);
        irq     <= val;
        irq_cur = val;
    endtask

    task automatic check_irq_now();
        logic [PACKET_WIDTH-1:0] pkt;
        pkt = expected_packet();
        @(negedge clk);
        check_equal(32'(cpu_irq), 32'(m_enable && pkt[PACKET_WIDTH-1 -: PRIORITY_WIDTH] < m_mask),
                    "cpu_irq");
    endtask

    task automatic check_winner();
        logic [PACKET_WIDTH-1:0] pkt;
        repeat (SETTLE_CYCLES) @(posedge clk);
        pkt = expected_packet();
        check_read(ADR_REQ_PRIORITY, 32'(pkt[PACKET_WIDTH-1 -: PRIORITY_WIDTH]), "req priority");
        check_read(ADR_REQ_FACTOR_ID, 32'(pkt[FACTOR_ID_WIDTH-1:0]), "req factor id");
        check_irq_now();
    endtask

    // ------------------------------------------------------------
    // test phases that each take well under 40 cycles
    // ------------------------------------------------------------

    task automatic program_factor();
        int          idx;
        logic [31:0] d;
        idx = int'(rand_bits(2));
        d   = rand_bits(32);
        bus_write(factor_adr(idx, FACTOR_ADR_ENABLE), d);
        f_en[idx] = d[0];
        d = rand_bits(32);
        bus_write(factor_adr(idx, FACTOR_ADR_PRIORITY), d);
        f_pri[idx] = d[PRIORITY_WIDTH-1:0];
        check_read(factor_adr(idx, FACTOR_ADR_ENABLE), 32'(f_en[idx]), "factor enable");
        check_read(factor_adr(idx, FACTOR_ADR_PRIORITY), 32'(f_pri[idx]), "factor priority");
        check_winner();
    endtask

    task automatic pulse_irq();
        int          idx;
        logic [31:0] v;
        v = rand_bits(FACTOR_NUM);
        drive_irq(v[FACTOR_NUM-1:0]);
        idx = int'(rand_bits(2));
        check_read(factor_adr(idx, FACTOR_ADR_LEVEL), 32'(v[idx]), "factor level");
        check_read(factor_adr(idx, FACTOR_ADR_PENDING), 32'(f_pend[idx]), "factor pending");
        drive_irq('0);
        check_winner();
    endtask

    task automatic change_mask();
        logic [31:0] d;
        d = rand_bits(32);
        bus_write(ADR_MASK, d);
        m_mask = d[PRIORITY_WIDTH-1:0];
        check_irq_now();
        check_read(ADR_MASK, 32'(m_mask), "mask");
    endtask

    task automatic clear_winner();
        int                      idx;
        logic [PACKET_WIDTH-1:0] pkt;
        pkt = expected_packet();
        idx = int'(pkt[FACTOR_ID_WIDTH-1:0]);
        bus_write(factor_adr(idx, FACTOR_ADR_PENDING), rand_bits(32) | 32'd1);
        f_pend[idx] = 1'b0;
        check_read(factor_adr(idx, FACTOR_ADR_PENDING), 32'd0, "pending after clear");
        check_winner();
    endtask

    task automatic toggle_enable();
        bus_write(ADR_ENABLE, rand_bits(32) & ~32'd1);
        m_enable = 1'b0;
        check_irq_now();
        check_read(ADR_ENABLE, 32'd0, "enable off");
        bus_write(ADR_ENABLE, rand_bits(32) | 32'd1);
        m_enable = 1'b1;
        // not yet enabled for a full cycle
        @(negedge clk);
        check_equal(32'(cpu_irq), 32'd0, "cpu_irq right after enable");
        check_read(ADR_REQ_PRIORITY, 32'd7, "req priority after enable");
        check_winner();
    endtask

    // ------------------------------------------------------------
    // main sequence
    // ------------------------------------------------------------

    initial begin
        reset     = 1'b1;
        irq       = '0;
        bus_adr   = '0;
        bus_dat_w = '0;
        bus_we    = 1'b0;
        bus_stb   = 1'b0;
        m_enable  = 1'b0;
        m_mask    = '1;
        f_en      = '0;
        f_pend    = '0;
        irq_cur   = '0;
        for (int i = 0; i < FACTOR_NUM; i++) begin
            f_pri[i] = '0;
        end
        repeat (3) @(posedge clk);
        reset <= 1'b0;

        check_read(ADR_ENABLE, 32'd0, "enable after reset");
        check_read(ADR_MASK, 32'd7, "mask after reset");
        check_read(ADR_REQ_PRIORITY, 32'd7, "req priority after reset");
        check_read(ADR_REQ_FACTOR_ID, 32'd0, "req factor id after reset");
        check_read(ADR_FACTOR_NUM, 32'd4, "factor count");
        check_read(ADR_PRIORITY_MAX, 32'd7, "max priority");
        check_irq_now();

        bus_write(ADR_ENABLE, 32'd1);
        m_enable = 1'b1;
        check_winner();

        for (int it = 0; it < N_ITER; it++) begin
            case (it % 5)
                0:       program_factor();
                1:       pulse_irq();
                2:       change_mask();
                3:       clear_winner();
                default: toggle_enable();
            endcase
        end

        $display("Simulation completed successfully");
        $finish;
    end

endmodule
